// ==== tb.f ====
+incdir+.
alu_pkg.sv
sm83_alu.sv
alu_sequencer.sv
alu_flags.sv
alu_unit_top.sv
tb_alu_checker.sv
tb_alu.sv

// ==== Makefile ====
# Verilator build and run of the ALU unit testbench.

SIM = obj_dir/Vtb_alu

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): tb.f *.sv *.svh
	verilator --binary --timing --assert -f tb.f --top-module tb_alu

run: $(SIM)
	./$(SIM) > sim.log
	cat sim.log
	grep -qx "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== tb_alu.sv ====
/*
 * Testbench top: clock, reset, LFSR driven requests, DUT and checker.
 */
`timescale 1ns/10ps
`default_nettype none
`include "alu_params.svh"

module tb_alu;

	localparam int          NUM_OPS      = int'(alu_pkg::OP_RES) + 1;
	localparam int          NUM_REQ      = 14 * NUM_OPS; /* Every op 14 times. */
	localparam int          DONE_TIMEOUT = 20;           /* Cycles to wait for done. */
	localparam logic [31:0] LFSR_TAPS    = 32'h8020_0003;
	localparam logic [31:0] LFSR_SEED    = 32'h2fe2;

	logic                 clk = 1'b0;
	logic                 reset;
	logic                 start;
	alu_pkg::alu_req_t    req;
	logic                 done;
	logic [`ALU_WORD-1:0] result;
	alu_pkg::alu_flags_t  flags;
	int                   errors;
	int                   checks;
	int                   timeouts;
	logic [31:0]          lfsr;

	alu_unit_top i_alu_unit_top (
		.clk, .reset, .start, .req,
		.done, .result, .flags
	);

	tb_alu_checker i_tb_alu_checker (
		.clk, .reset, .start, .req, .done, .result, .flags,
		.errors, .checks
	);

	always #20 clk = ~clk; /* 40 ns period. */

	/* Galois form, shifts right and folds the taps in on a one. */
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v    = {v[30:0], lfsr[0]};
			lfsr = lfsr_next(lfsr); /* One step per bit. */
		end
	endtask

	task automatic random_op(output int idx);
		logic [31:0] v;
		take_bits(5, v);
		idx = int'(v[4:0]) % NUM_OPS;
	endtask

	task automatic random_req(input int op_idx, output alu_pkg::alu_req_t r);
		logic [31:0] v;
		r.op = alu_pkg::alu_op_t'(op_idx);
		take_bits(`ALU_WORD, v);
		r.a = v[`ALU_WORD-1:0];
		take_bits(`ALU_WORD, v);
		r.b = v[`ALU_WORD-1:0];
		take_bits(2, v);
		if (v[1:0] == 2'd0) begin
			r.b = r.a; /* Equal operands, so SUB and CP reach zero. */
		end
		take_bits(3, v);
		r.bit_sel = v[2:0];
		take_bits(4, v);
		r.flags_in = alu_pkg::alu_flags_t'(v[3:0]);
	endtask

	/* Called on a falling edge. poke_at picks a cycle for a start while busy. */
	task automatic run_request(input alu_pkg::alu_req_t r, input int poke_at);
		alu_pkg::alu_req_t junk;
		int                idx;
		int                n;
		start = 1'b1;
		req   = r;
		n     = 0;
		do begin
			@(negedge clk);
			n++;
			random_op(idx);
			random_req(idx, junk);
			start = (n == poke_at);
			req   = junk; /* The captured request must not follow the port. */
		end while (!done && n < DONE_TIMEOUT);
		if (!done) begin
			timeouts++;
			$display("Timeout: no done within %0d cycles of the %s request at %0t",
				DONE_TIMEOUT, r.op.name(), $time);
		end
	endtask

	initial begin
		alu_pkg::alu_req_t r;
		logic [31:0]       v;
		reset    = 1'b1;
		start    = 1'b0;
		req      = '0;
		timeouts = 0;
		lfsr     = LFSR_SEED;
		repeat (4) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		repeat (6) @(negedge clk); /* Idle, outputs stay zero. */
		for (int i = 0; i < NUM_REQ && timeouts == 0; i++) begin
			random_req(i % NUM_OPS, r);
			take_bits(2, v);
			run_request(r, int'(v[1:0])); /* 0 means no extra start. */
		end
		start = 1'b0;
		repeat (8) @(negedge clk); /* Catch a late or extra done. */
		$display("Requests checked: %0d of %0d, errors: %0d, timeouts: %0d",
			checks, NUM_REQ, errors, timeouts);
		if (errors == 0 && timeouts == 0 && checks == NUM_REQ) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb_alu_checker.sv ====
/*
 * Reference model of the ALU operations and a monitor that checks
 * done timing, result and flags at the DUT ports.
 */
`timescale 1ns/10ps
`default_nettype none
`include "alu_params.svh"

module tb_alu_checker (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 start,
	input  alu_pkg::alu_req_t    req,
	input  logic                 done,
	input  logic [`ALU_WORD-1:0] result,
	input  alu_pkg::alu_flags_t  flags,
	output int                   errors,
	output int                   checks  /* Done pulses compared. */
);

	localparam int WORD    = `ALU_WORD;
	localparam int NIB     = `ALU_NIBBLE;
	localparam int STEPS   = `ALU_STEPS;
	localparam int NIB_MAX = (1 << NIB) - 1;

	typedef struct packed {
		logic [`ALU_WORD-1:0] result;
		alu_pkg::alu_flags_t  flags;
	} outcome_t;

	logic              pending;  /* Accepted start, done not yet seen. */
	int                age;      /* Cycles since the accepted start. */
	outcome_t          expected;
	outcome_t          held;     /* Outputs as of the last done. */
	alu_pkg::alu_req_t cur_req;
	alu_pkg::alu_op_t  cur_op;

	/* SM83 behavior of one request, straight from the flag rules. */
	function automatic outcome_t model(input alu_pkg::alu_req_t r);
		outcome_t             e;
		int                   cy;
		int                   sum;
		logic [`ALU_WORD-1:0] a;
		logic [`ALU_WORD-1:0] b;
		logic [`ALU_WORD-1:0] mask;
		a    = r.a;
		b    = r.b;
		mask = WORD'(1) << r.bit_sel;
		e    = '0;
		case (r.op)
			alu_pkg::OP_ADD, alu_pkg::OP_ADC: begin
				cy        = (r.op == alu_pkg::OP_ADC) ? int'(r.flags_in.c) : 0;
				sum       = int'(a) + int'(b) + cy;
				e.result  = sum[WORD-1:0];
				e.flags.h = (int'(a[NIB-1:0]) + int'(b[NIB-1:0]) + cy) > NIB_MAX;
				e.flags.c = sum[WORD];
			end
			alu_pkg::OP_SUB, alu_pkg::OP_SBC, alu_pkg::OP_CP: begin
				cy        = (r.op == alu_pkg::OP_SBC) ? int'(r.flags_in.c) : 0;
				sum       = int'(a) - int'(b) - cy;
				e.result  = sum[WORD-1:0]; /* Wraps like the 8-bit register. */
				e.flags.n = 1'b1;
				e.flags.h = int'(a[NIB-1:0]) < int'(b[NIB-1:0]) + cy; /* Borrow from bit 4. */
				e.flags.c = int'(a) < int'(b) + cy;
			end
			alu_pkg::OP_AND: begin
				e.result  = a & b;
				e.flags.h = 1'b1;
			end
			alu_pkg::OP_OR:  e.result = a | b;
			alu_pkg::OP_XOR: e.result = a ^ b;
			alu_pkg::OP_RLC: begin
				e.result  = {a[WORD-2:0], a[WORD-1]};
				e.flags.c = a[WORD-1];
			end
			alu_pkg::OP_RRC: begin
				e.result  = {a[0], a[WORD-1:1]};
				e.flags.c = a[0];
			end
			alu_pkg::OP_RL: begin
				e.result  = {a[WORD-2:0], r.flags_in.c}; /* Old carry enters. */
				e.flags.c = a[WORD-1];
			end
			alu_pkg::OP_RR: begin
				e.result  = {r.flags_in.c, a[WORD-1:1]};
				e.flags.c = a[0];
			end
			alu_pkg::OP_SLA: begin
				e.result  = {a[WORD-2:0], 1'b0};
				e.flags.c = a[WORD-1];
			end
			alu_pkg::OP_SRA: begin
				e.result  = {a[WORD-1], a[WORD-1:1]}; /* Sign stays. */
				e.flags.c = a[0];
			end
			alu_pkg::OP_SRL: begin
				e.result  = {1'b0, a[WORD-1:1]};
				e.flags.c = a[0];
			end
			alu_pkg::OP_BIT: begin
				e.result  = a & mask;
				e.flags.h = 1'b1;
				e.flags.c = r.flags_in.c;
			end
			alu_pkg::OP_SET: e.result = a | mask;
			alu_pkg::OP_RES: e.result = a & ~mask;
			default: ;
		endcase
		e.flags.z = (e.result == '0); /* For BIT, set when the bit is clear. */
		if (r.op == alu_pkg::OP_CP) begin
			e.result = a; /* Compare only, Z still from a - b. */
		end
		if (r.op == alu_pkg::OP_SET || r.op == alu_pkg::OP_RES) begin
			e.flags = r.flags_in;
		end
		return e;
	endfunction

	task automatic compare_outputs(input outcome_t got);
		checks++;
		if (got.result !== expected.result) begin
			errors++;
			$display("Fail at %0t: %s a=%h b=%h c=%b bit=%0d, result %h, expected %h",
				$time, cur_op.name(), cur_req.a, cur_req.b, cur_req.flags_in.c,
				cur_req.bit_sel, got.result, expected.result);
		end
		if (got.flags !== expected.flags) begin
			errors++;
			$display("Fail at %0t: %s a=%h b=%h c=%b bit=%0d, flags znhc %b, expected %b",
				$time, cur_op.name(), cur_req.a, cur_req.b, cur_req.flags_in.c,
				cur_req.bit_sel, got.flags, expected.flags);
		end
	endtask

	/* Samples on the rising edge, before the DUT registers update. */
	always @(posedge clk) begin
		outcome_t got;
		logic     at_done;
		got.result = result;
		got.flags  = flags;
		at_done    = 1'b0;
		if (reset) begin
			pending = 1'b0;
			age     = 0;
			held    = '0; /* Result and flags reset to zero. */
			errors  = 0;
			checks  = 0;
		end else begin
			if (pending) begin
				age++;
				if (age == STEPS) begin
					pending = 1'b0;
					if (done) begin
						at_done = 1'b1;
						compare_outputs(got);
						held = got;
					end else begin
						errors++;
						$display("Done missing at %0t, %0d cycles after the %s start",
							$time, STEPS, cur_op.name());
					end
				end else if (done) begin
					errors++;
					$display("Done came early at %0t, %0d cycles after the %s start",
						$time, age, cur_op.name());
				end
			end else if (done) begin
				errors++;
				$display("Extra done at %0t with no request in progress", $time);
			end
			/* Outputs only move together with done. */
			if (!at_done && got !== held) begin
				errors++;
				$display("Fail at %0t: outputs changed without done, result %h flags %b",
					$time, got.result, got.flags);
				held = got;
			end
			if (start && !pending) begin
				pending  = 1'b1; /* Starts while busy are dropped. */
				age      = 0;
				cur_req  = req;
				cur_op   = req.op;
				expected = model(req);
			end
		end
	end

endmodule

`default_nettype wire

// ==== alu_unit_top.sv ====
/*
 * ALU unit top: sequencer, nibble-serial datapath and flag logic.
 */
`timescale 1ns/10ps
`default_nettype none
`include "alu_params.svh"

module alu_unit_top (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 start,
	input  alu_pkg::alu_req_t    req,
	output logic                 done,
	output logic [`ALU_WORD-1:0] result,
	output alu_pkg::alu_flags_t  flags
);

	alu_pkg::alu_ctrl_t   ctrl;
	alu_pkg::alu_req_t    op_req;
	logic [`ALU_WORD-1:0] din, dout;
	logic [1:0]           step;
	logic                 busy;
	logic                 carry, zero, shift_dbh, shift_dbl;

	alu_sequencer i_alu_sequencer (
		.clk, .reset, .start, .req,
		.ctrl, .din, .step, .busy, .op_req, .done
	);

	/* Sign is not part of the SM83 flag set. */
	sm83_alu i_sm83_alu (
		.clk, .reset, .din, .ctrl,
		.dout, .carry, .zero, .sign(),
		.shift_dbh, .shift_dbl
	);

	alu_flags i_alu_flags (
		.clk, .reset, .step, .busy, .op_req,
		.dout, .carry, .zero, .shift_dbh, .shift_dbl,
		.result, .flags
	);

endmodule

`default_nettype wire

// ==== alu_flags.sv ====
/*
 * Low-pass carry register, result register and Z N H C flag formation.
 */
`timescale 1ns/10ps
`default_nettype none
`include "alu_params.svh"

module alu_flags (
	input  logic                 clk,
	input  logic                 reset,
	input  logic [1:0]           step,
	input  logic                 busy,
	input  alu_pkg::alu_req_t    op_req,
	input  logic [`ALU_WORD-1:0] dout,
	input  logic                 carry,
	input  logic                 zero,
	input  logic                 shift_dbh,
	input  logic                 shift_dbl,
	output logic [`ALU_WORD-1:0] result,
	output alu_pkg::alu_flags_t  flags
);

	logic                low_c; /* Carry out of the low nibble. */
	logic                low_pass, last_pass;
	alu_pkg::alu_flags_t nxt_flags;

	assign low_pass  = busy && (step == 2'd2);
	assign last_pass = busy && (step == 2'd3);

	always_comb begin
		nxt_flags = '{z: zero, n: 1'b0, h: 1'b0, c: 1'b0};
		case (op_req.op)
			alu_pkg::OP_ADD, alu_pkg::OP_ADC: begin
				nxt_flags.h = low_c;
				nxt_flags.c = carry;
			end
			alu_pkg::OP_SUB, alu_pkg::OP_SBC, alu_pkg::OP_CP: begin
				nxt_flags.n = 1'b1;
				nxt_flags.h = !low_c; /* No carry means borrow. */
				nxt_flags.c = !carry;
			end
			alu_pkg::OP_AND: nxt_flags.h = 1'b1;
			alu_pkg::OP_OR, alu_pkg::OP_XOR: ;
			alu_pkg::OP_RLC, alu_pkg::OP_RL, alu_pkg::OP_SLA: nxt_flags.c = shift_dbh;
			alu_pkg::OP_RRC, alu_pkg::OP_RR, alu_pkg::OP_SRA, alu_pkg::OP_SRL: begin
				nxt_flags.c = shift_dbl;
			end
			alu_pkg::OP_BIT: begin
				nxt_flags.h = 1'b1;
				nxt_flags.c = op_req.flags_in.c;
			end
			default: nxt_flags = op_req.flags_in; /* SET and RES. */
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			low_c <= 1'b0;
		end else if (low_pass) begin
			low_c <= carry;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			result <= '0;
			flags  <= '0;
		end else if (last_pass) begin
			result <= (op_req.op == alu_pkg::OP_CP) ? op_req.a : dout; /* CP only compares. */
			flags  <= nxt_flags;
		end
	end

	/* The final pass uses a carry held in the cycle just before. */
	a_low_c_step: assert property (@(posedge clk) disable iff (reset)
		last_pass |-> $past(low_pass));

endmodule

`default_nettype wire

// ==== alu_sequencer.sv ====
/*
 * Request capture, step counter and per-step control decode for the ALU datapath.
 */
`timescale 1ns/10ps
`default_nettype none
`include "alu_params.svh"

module alu_sequencer (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 start,  /* One cycle request pulse. */
	input  alu_pkg::alu_req_t    req,
	output alu_pkg::alu_ctrl_t   ctrl,
	output logic [`ALU_WORD-1:0] din,
	output logic [1:0]           step,   /* Current step, 0 in the start cycle. */
	output logic                 busy,   /* Steps 1 to 3 in progress. */
	output alu_pkg::alu_req_t    op_req, /* Captured request. */
	output logic                 done
);

	localparam logic [1:0] LAST_STEP = 2'(`ALU_STEPS - 1);

	logic               go;
	logic [1:0]         cnt;
	logic [1:0]         cur_step;
	logic               is_shift;
	alu_pkg::alu_ctrl_t fn; /* Operation dependent strobes. */

	assign go       = start && !busy; /* Start while busy is dropped. */
	assign cur_step = busy ? cnt : 2'd0;
	assign step     = cur_step;

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			cnt  <= 2'd0;
			done <= 1'b0;
		end else begin
			done <= busy && (cnt == LAST_STEP);
			if (go) begin
				busy <= 1'b1;
				cnt  <= 2'd1; /* Step 0 runs in the start cycle. */
			end else if (busy) begin
				cnt <= cnt + 2'd1;
				if (cnt == LAST_STEP) begin
					busy <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (go) begin
			op_req <= req;
		end
	end

	/* Step 0 takes a straight from the request. */
	assign din = ctrl.din_sel ? op_req.b : (busy ? op_req.a : req.a);

	/* Core function, shift and mask settings per operation. */
	always_comb begin
		fn = '0;
		case (op_req.op)
			alu_pkg::OP_ADD: ;
			alu_pkg::OP_ADC: fn.carry_in = op_req.flags_in.c;
			alu_pkg::OP_SUB, alu_pkg::OP_CP: begin
				fn.negate   = 1'b1;
				fn.carry_in = 1'b1; /* a + ~b + 1. */
			end
			alu_pkg::OP_SBC: begin
				fn.negate   = 1'b1;
				fn.carry_in = !op_req.flags_in.c; /* Borrow in is inverted. */
			end
			alu_pkg::OP_AND: begin
				fn.force_carry = 1'b1;
				fn.carry_in    = 1'b1;
			end
			alu_pkg::OP_OR: begin
				fn.no_carry_out = 1'b1;
				fn.force_carry  = 1'b1;
				fn.ignore_carry = 1'b1;
			end
			alu_pkg::OP_XOR: fn.no_carry_out = 1'b1;
			alu_pkg::OP_RLC: begin
				fn.shift_l  = 1'b1;
				fn.shift_in = op_req.a[`ALU_WORD-1];
			end
			alu_pkg::OP_RL: begin
				fn.shift_l  = 1'b1;
				fn.shift_in = op_req.flags_in.c;
			end
			alu_pkg::OP_SLA: fn.shift_l = 1'b1;
			alu_pkg::OP_RRC: begin
				fn.shift_r  = 1'b1;
				fn.shift_in = op_req.a[0];
			end
			alu_pkg::OP_RR: begin
				fn.shift_r  = 1'b1;
				fn.shift_in = op_req.flags_in.c;
			end
			alu_pkg::OP_SRA: begin
				fn.shift_r  = 1'b1;
				fn.shift_in = op_req.a[`ALU_WORD-1]; /* Sign kept. */
			end
			alu_pkg::OP_SRL: fn.shift_r = 1'b1;
			alu_pkg::OP_BIT: begin
				fn.bs_oe       = 1'b1;
				fn.force_carry = 1'b1; /* AND with the mask. */
				fn.carry_in    = 1'b1;
			end
			alu_pkg::OP_SET: begin
				fn.bs_oe        = 1'b1;
				fn.no_carry_out = 1'b1; /* OR with the mask. */
				fn.force_carry  = 1'b1;
				fn.ignore_carry = 1'b1;
			end
			alu_pkg::OP_RES: begin
				fn.bs_oe       = 1'b1;
				fn.negate      = 1'b1; /* AND with the inverted mask. */
				fn.force_carry = 1'b1;
				fn.carry_in    = 1'b1;
			end
			default: ;
		endcase
	end

	assign is_shift = fn.shift_l || fn.shift_r;

	always_comb begin
		ctrl = '0; /* Idle, all strobes off. */
		if (go || busy) begin
			case (cur_step)
				2'd0: begin
					ctrl.shift_oe = 1'b1;
					ctrl.load_a   = 1'b1;
				end
				2'd1: begin
					ctrl.din_sel  = 1'b1;
					ctrl.bsel     = op_req.bit_sel;
					ctrl.bs_oe    = fn.bs_oe;
					ctrl.shift_oe = !fn.bs_oe;
					ctrl.load_b   = 1'b1;
				end
				default: begin
					ctrl.no_carry_out = fn.no_carry_out;
					ctrl.force_carry  = fn.force_carry;
					ctrl.ignore_carry = fn.ignore_carry;
					ctrl.negate       = fn.negate;
					if (cur_step == 2'd2) begin
						ctrl.op_low   = 1'b1;
						ctrl.carry_in = fn.carry_in;
					end else begin
						ctrl.op_b_high = 1'b1;
						ctrl.shift_l   = fn.shift_l;
						ctrl.shift_r   = fn.shift_r;
						ctrl.shift_in  = fn.shift_in;
						ctrl.shift_oe  = is_shift;
						ctrl.result_oe = !is_shift;
					end
				end
			endcase
		end
	end

	a_done_pulse: assert property (@(posedge clk) disable iff (reset) done |=> !done);

endmodule

`default_nettype wire

// ==== sm83_alu.sv ====
/*
 * Nibble-serial ALU datapath: operand registers, ripple core with held
 * inter-pass carry, one-bit shifter, bit mask generator and bus select.
 */
`timescale 1ns/10ps
`default_nettype none
`include "alu_params.svh"

module sm83_alu (
	input  logic                 clk,
	input  logic                 reset,
	input  logic [`ALU_WORD-1:0] din,       /* Into the shifter. */
	input  alu_pkg::alu_ctrl_t   ctrl,
	output logic [`ALU_WORD-1:0] dout,      /* The ALU bus. */
	output logic                 carry,     /* Carry out of the core. */
	output logic                 zero,      /* Bus is all zero. */
	output logic                 sign,
	output logic                 shift_dbh, /* Bit leaving on a left shift. */
	output logic                 shift_dbl  /* Bit leaving on a right shift. */
);

	localparam int NIB  = `ALU_NIBBLE;
	localparam int WORD = `ALU_WORD;

	typedef logic [NIB-1:0] nib_t;

	typedef struct packed {
		nib_t h;
		nib_t l;
	} word_t;

	/* One core bit, R S V pick the function. Returns {r, c_out}. */
	function automatic logic [1:0] alu_slice(input logic a, input logic b, input logic c_in,
			input logic r_sig, input logic s_sig, input logic v_sig);
		logic nc;
		logic r;
		nc = !(((a | b) & c_in) | (a & b) | s_sig); /* Low when carry is generated or forced. */
		r  = (a & b & c_in) | ((a | b | c_in) & (v_sig | nc));
		return {r, !(r_sig | nc)};
	endfunction

	word_t op_a, op_b;           /* Operand registers. */
	word_t shifted, op_bs, result, bus;
	nib_t  core_op_a, core_op_b, core_b_sel, core_result;
	nib_t  res_lo;               /* Core result of the low pass. */
	logic  carry_lo;             /* Carry out of the low pass. */
	logic  chain_cin;

	/* High pass continues from the held low carry. */
	assign chain_cin  = ctrl.op_low ? ctrl.carry_in : carry_lo;
	assign core_op_a  = ctrl.op_low ? op_a.l : op_a.h;
	assign core_b_sel = ctrl.op_b_high ? op_b.h : op_b.l;
	assign core_op_b  = ctrl.negate ? ~core_b_sel : core_b_sel;

	always_comb begin
		logic       c;
		logic [1:0] rc;
		c = chain_cin;
		for (int i = 0; i < NIB; i++) begin
			rc = alu_slice(core_op_a[i], core_op_b[i], c,
				ctrl.no_carry_out, ctrl.force_carry, ctrl.ignore_carry);
			core_result[i] = rc[1];
			c = rc[0]; /* Ripple to the next bit. */
		end
		carry = c;
	end

	always_comb begin
		if (ctrl.shift_l) begin
			shifted = {din[WORD-2:0], ctrl.shift_in};
		end else if (ctrl.shift_r) begin
			shifted = {ctrl.shift_in, din[WORD-1:1]};
		end else begin
			shifted = din; /* Pass through. */
		end
	end

	assign op_bs  = word_t'(WORD'(1) << ctrl.bsel);
	assign result = {core_result, res_lo};

	always_comb begin
		unique case (1'b1)
			ctrl.result_oe: bus = result;
			ctrl.shift_oe:  bus = shifted;
			ctrl.op_a_oe:   bus = op_a;
			ctrl.bs_oe:     bus = op_bs;
			default:        bus = '0; /* Nothing driving. */
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			op_a <= '0;
		end else if (ctrl.load_a) begin
			op_a <= bus;
		end else if (ctrl.load_a_zero) begin
			op_a <= '0;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			op_b <= '0;
		end else if (ctrl.load_b) begin
			op_b <= bus;
		end else if (ctrl.load_b_zero) begin
			op_b <= '0;
		end
	end

	/* Low pass result and carry wait here for the high pass. */
	always_ff @(posedge clk) begin
		if (reset) begin
			res_lo   <= '0;
			carry_lo <= 1'b0;
		end else if (ctrl.op_low) begin
			res_lo   <= core_result;
			carry_lo <= carry;
		end
	end

	assign dout      = bus;
	assign zero      = (bus == '0);
	assign sign      = bus[WORD-1];
	assign shift_dbh = din[WORD-1];
	assign shift_dbl = din[0];

	/* The sequencer never drives two sources onto the bus. */
	a_bus_onehot: assert property (@(posedge clk) disable iff (reset)
		$onehot0({ctrl.result_oe, ctrl.shift_oe, ctrl.op_a_oe, ctrl.bs_oe}));
	a_shift_dir: assert property (@(posedge clk) disable iff (reset)
		!(ctrl.shift_l && ctrl.shift_r));
	a_load_a: assert property (@(posedge clk) disable iff (reset)
		!(ctrl.load_a && ctrl.load_a_zero));
	a_load_b: assert property (@(posedge clk) disable iff (reset)
		!(ctrl.load_b && ctrl.load_b_zero));

endmodule

`default_nettype wire

// ==== alu_pkg.sv ====
/*
 * Operation codes and the request, flag and datapath control types of the ALU unit.
 */
`default_nettype none
`include "alu_params.svh"

package alu_pkg;

	/* SM83 operations as driven on req.op. */
	typedef enum logic [4:0] {
		OP_ADD = 5'd0,  OP_ADC = 5'd1,  OP_SUB = 5'd2,  OP_SBC = 5'd3,
		OP_CP  = 5'd4,  OP_AND = 5'd5,  OP_OR  = 5'd6,  OP_XOR = 5'd7,
		OP_RLC = 5'd8,  OP_RRC = 5'd9,  OP_RL  = 5'd10, OP_RR  = 5'd11,
		OP_SLA = 5'd12, OP_SRA = 5'd13, OP_SRL = 5'd14,
		OP_BIT = 5'd15, OP_SET = 5'd16, OP_RES = 5'd17
	} alu_op_t;

	typedef struct packed {
		logic z; /* Zero. */
		logic n; /* Subtract. */
		logic h; /* Half carry, out of the low nibble. */
		logic c; /* Carry. */
	} alu_flags_t;

	typedef struct packed {
		alu_op_t              op;
		logic [`ALU_WORD-1:0] a;
		logic [`ALU_WORD-1:0] b;
		logic [2:0]           bit_sel;  /* For BIT, SET and RES. */
		alu_flags_t           flags_in; /* Flags before the operation. */
	} alu_req_t;

	typedef struct packed {
		logic       load_a, load_b;           /* Load bus into A or B. */
		logic       load_a_zero, load_b_zero; /* Clear A or B. */
		logic       shift_l, shift_r;
		logic       shift_in;                 /* Bit entering on a shift. */
		logic       carry_in;                 /* Carry into the low pass. */
		logic       result_oe, shift_oe;      /* Bus drivers, at most one set. */
		logic       op_a_oe, bs_oe;
		logic       no_carry_out;             /* R. */
		logic       force_carry;              /* S. */
		logic       ignore_carry;             /* V. */
		logic       negate;                   /* Invert B into the core. */
		logic       op_low;                   /* 1 selects low half of A. */
		logic       op_b_high;                /* 1 selects high half of B. */
		logic       din_sel;                  /* 1 puts operand b on din. */
		logic [2:0] bsel;                     /* Bit for the mask generator. */
	} alu_ctrl_t;

endpackage

`default_nettype wire

// ==== alu_params.svh ====
/*
 * Width and step count macros for the nibble-serial ALU unit.
 */
`ifndef ALU_PARAMS_SVH
`define ALU_PARAMS_SVH

/* Width of one pass through the core. */
`define ALU_NIBBLE 4

/* Operand and result width, two passes. */
`define ALU_WORD (2 * `ALU_NIBBLE)

/* Cycles from an accepted start to done.
 * Also the number of datapath steps.
 */
`define ALU_STEPS 4

`endif
